// File: design/axi_conv_pkg.sv
package axi_conv_pkg;

  // AXI response codes.
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_exokay = 2'b01; // exclusive access ok.
  localparam logic [1:0] resp_slverr = 2'b10;
  localparam logic [1:0] resp_decerr = 2'b11;

  // burst type codes.
  localparam logic [1:0] burst_fixed = 2'b00;
  localparam logic [1:0] burst_incr  = 2'b01;
  localparam logic [1:0] burst_wrap  = 2'b10;

  // AXI3 bursts carry at most 16 beats.
  localparam int axi3_max_len = 15;

  localparam int axi3_len_width = 4; // AXI3 arlen.
  localparam int axi4_len_width = 8; // AXI4 arlen.

endpackage

// File: design/ar_burst_splitter.sv
`timescale 1ns/100ps

module ar_burst_splitter #(
  parameter int id_width   = 4,
  parameter int addr_width = 32
) (
  input  logic                                  aclk,
  input  logic                                  rst,
  // AXI4 request side.
  input  logic [id_width-1:0]                   s_arid,
  input  logic [addr_width-1:0]                 s_araddr,
  input  logic [axi_conv_pkg::axi4_len_width-1:0] s_arlen,
  input  logic [2:0]                            s_arsize,
  input  logic [1:0]                            s_arburst,
  input  logic                                  s_arvalid,
  output logic                                  s_arready,
  // AXI3 request side.
  output logic [id_width-1:0]                   m_arid,
  output logic [addr_width-1:0]                 m_araddr,
  output logic [axi_conv_pkg::axi3_len_width-1:0] m_arlen,
  output logic [2:0]                            m_arsize,
  output logic [1:0]                            m_arburst,
  output logic                                  m_arvalid,
  input  logic                                  m_arready,
  // split flag queue.
  output logic                                  cmd_push,
  output logic                                  cmd_split,
  input  logic                                  cmd_full
);

  import axi_conv_pkg::*;

  logic                      busy;
  logic [axi4_len_width-1:0] rem_len; // beats left, minus one.
  logic                      piece_split;
  logic [addr_width-1:0]     addr_step;

  // only INCR bursts are long enough to need cutting.
  assign piece_split = (m_arburst == burst_incr) &&
                       (rem_len > axi4_len_width'(axi3_max_len));

  assign m_arlen = piece_split ? axi3_len_width'(axi3_max_len)
                               : rem_len[axi3_len_width-1:0];

  // 16 beats of the transfer size.
  assign addr_step = addr_width'(axi3_max_len + 1) << m_arsize;

  // a full queue holds the next piece back.
  assign m_arvalid = busy & ~cmd_full;

  assign cmd_push  = m_arvalid & m_arready;
  assign cmd_split = piece_split;

  always_ff @(posedge aclk) begin
    if (rst) begin
      busy      <= 1'b0;
      s_arready <= 1'b0;
    end else begin
      if (s_arvalid && s_arready) begin
        busy      <= 1'b1;
        s_arready <= 1'b0;
      end else if (cmd_push && !piece_split) begin
        busy      <= 1'b0; // final piece gone.
        s_arready <= 1'b1;
      end else if (!busy) begin
        s_arready <= 1'b1;
      end
    end
  end

  // request payload and running address.
  always_ff @(posedge aclk) begin
    if (s_arvalid && s_arready) begin
      m_arid    <= s_arid;
      m_araddr  <= s_araddr;
      m_arsize  <= s_arsize;
      m_arburst <= s_arburst;
      rem_len   <= s_arlen;
    end else if (cmd_push && piece_split) begin
      m_araddr <= m_araddr + addr_step;
      rem_len  <= rem_len - axi4_len_width'(axi3_max_len + 1);
    end
  end

  // a piece never drops beats of the request.
  assert property (@(posedge aclk) disable iff (rst)
    m_arvalid |-> piece_split || (rem_len <= axi4_len_width'(axi3_max_len)));

  // request stays put until the AXI3 slave takes it.
  assert property (@(posedge aclk) disable iff (rst)
    m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr) && $stable(m_arlen));

endmodule

// File: design/split_cmd_queue.sv
`timescale 1ns/100ps

module split_cmd_queue #(
  parameter int queue_depth = 4 // power of two, at least 2.
) (
  input  logic aclk,
  input  logic rst,
  input  logic cmd_push,
  input  logic cmd_split,
  output logic cmd_full,
  output logic cmd_valid,
  output logic cmd_split_out,
  input  logic cmd_ready
);

  localparam int ptr_width = $clog2(queue_depth);

  logic                 flags [queue_depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;
  logic                 do_pop;

  assign cmd_full      = (count == (ptr_width + 1)'(queue_depth));
  assign cmd_valid     = (count != '0);
  assign cmd_split_out = flags[rd_ptr];
  assign do_pop        = cmd_ready & cmd_valid;

  always_ff @(posedge aclk) begin
    if (cmd_push) begin
      flags[wr_ptr] <= cmd_split;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (cmd_push) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps at queue_depth.
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (cmd_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !cmd_push) begin
        count <= count - 1'b1;
      end
    end
  end

  assert property (@(posedge aclk) disable iff (rst)
    !(cmd_push && cmd_full));

  // data path pops only what the address path pushed.
  assert property (@(posedge aclk) disable iff (rst)
    !(cmd_ready && !cmd_valid));

endmodule

// File: design/r_axi3_conv.sv
`timescale 1ns/100ps

module r_axi3_conv #(
  parameter int id_width   = 4,
  parameter int data_width = 32
) (
  input  logic                  aclk,
  input  logic                  rst,
  input  logic                  cmd_valid,
  input  logic                  cmd_split,
  output logic                  cmd_ready,
  // AXI4 read data side.
  output logic [id_width-1:0]   s_rid,
  output logic [data_width-1:0] s_rdata,
  output logic [1:0]            s_rresp,
  output logic                  s_rlast,
  output logic                  s_rvalid,
  input  logic                  s_rready,
  // AXI3 read data side.
  input  logic [id_width-1:0]   m_rid,
  input  logic [data_width-1:0] m_rdata,
  input  logic [1:0]            m_rresp,
  input  logic                  m_rlast,
  input  logic                  m_rvalid,
  output logic                  m_rready
);

  import axi_conv_pkg::*;

  logic                      r_beat;
  logic [axi3_len_width-1:0] beat_cnt; // beats seen in the current piece.

  // no command means the burst is not ours yet.
  assign s_rvalid = m_rvalid & cmd_valid;
  assign m_rready = s_rready & cmd_valid;
  assign r_beat   = s_rvalid & s_rready;

  assign s_rid   = m_rid;
  assign s_rdata = m_rdata;
  assign s_rresp = m_rresp;
  assign s_rlast = m_rlast & ~cmd_split; // hide inner piece ends.

  assign cmd_ready = r_beat & m_rlast;

  always_ff @(posedge aclk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (r_beat) begin
      beat_cnt <= m_rlast ? '0 : beat_cnt + 1'b1;
    end
  end

  assert property (@(posedge aclk) disable iff (rst)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rid) && $stable(s_rdata) &&
      $stable(s_rresp) && $stable(s_rlast));

  // AXI3 slave must close every piece within 16 beats.
  assert property (@(posedge aclk) disable iff (rst)
    r_beat && !m_rlast |-> beat_cnt != axi3_len_width'(axi3_max_len));

  // no exclusive reads are issued.
  assert property (@(posedge aclk) disable iff (rst)
    s_rvalid |-> s_rresp != resp_exokay);

endmodule

// File: design/axi4_to_axi3_read.sv
`timescale 1ns/100ps

module axi4_to_axi3_read #(
  parameter int id_width    = 4,
  parameter int addr_width  = 32,
  parameter int data_width  = 32,
  parameter int queue_depth = 4
) (
  input  logic                                    aclk,
  input  logic                                    rst,
  // AXI4 AR from the master.
  input  logic [id_width-1:0]                     s_arid,
  input  logic [addr_width-1:0]                   s_araddr,
  input  logic [axi_conv_pkg::axi4_len_width-1:0] s_arlen,
  input  logic [2:0]                              s_arsize,
  input  logic [1:0]                              s_arburst,
  input  logic                                    s_arvalid,
  output logic                                    s_arready,
  // AXI4 R to the master.
  output logic [id_width-1:0]                     s_rid,
  output logic [data_width-1:0]                   s_rdata,
  output logic [1:0]                              s_rresp,
  output logic                                    s_rlast,
  output logic                                    s_rvalid,
  input  logic                                    s_rready,
  // AXI3 AR to the slave.
  output logic [id_width-1:0]                     m_arid,
  output logic [addr_width-1:0]                   m_araddr,
  output logic [axi_conv_pkg::axi3_len_width-1:0] m_arlen,
  output logic [2:0]                              m_arsize,
  output logic [1:0]                              m_arburst,
  output logic                                    m_arvalid,
  input  logic                                    m_arready,
  // AXI3 R from the slave.
  input  logic [id_width-1:0]                     m_rid,
  input  logic [data_width-1:0]                   m_rdata,
  input  logic [1:0]                              m_rresp,
  input  logic                                    m_rlast,
  input  logic                                    m_rvalid,
  output logic                                    m_rready
);

  logic cmd_push;
  logic cmd_split;     // flag of the piece being issued.
  logic cmd_full;
  logic cmd_valid;
  logic cmd_split_out; // flag of the piece being returned.
  logic cmd_ready;

  ar_burst_splitter #(
    .id_width  (id_width),
    .addr_width(addr_width)
  ) u_ar_burst_splitter (
    .aclk     (aclk),
    .rst      (rst),
    .s_arid   (s_arid),
    .s_araddr (s_araddr),
    .s_arlen  (s_arlen),
    .s_arsize (s_arsize),
    .s_arburst(s_arburst),
    .s_arvalid(s_arvalid),
    .s_arready(s_arready),
    .m_arid   (m_arid),
    .m_araddr (m_araddr),
    .m_arlen  (m_arlen),
    .m_arsize (m_arsize),
    .m_arburst(m_arburst),
    .m_arvalid(m_arvalid),
    .m_arready(m_arready),
    .cmd_push (cmd_push),
    .cmd_split(cmd_split),
    .cmd_full (cmd_full)
  );

  split_cmd_queue #(
    .queue_depth(queue_depth)
  ) u_split_cmd_queue (
    .aclk         (aclk),
    .rst          (rst),
    .cmd_push     (cmd_push),
    .cmd_split    (cmd_split),
    .cmd_full     (cmd_full),
    .cmd_valid    (cmd_valid),
    .cmd_split_out(cmd_split_out),
    .cmd_ready    (cmd_ready)
  );

  r_axi3_conv #(
    .id_width  (id_width),
    .data_width(data_width)
  ) u_r_axi3_conv (
    .aclk     (aclk),
    .rst      (rst),
    .cmd_valid(cmd_valid),
    .cmd_split(cmd_split_out),
    .cmd_ready(cmd_ready),
    .s_rid    (s_rid),
    .s_rdata  (s_rdata),
    .s_rresp  (s_rresp),
    .s_rlast  (s_rlast),
    .s_rvalid (s_rvalid),
    .s_rready (s_rready),
    .m_rid    (m_rid),
    .m_rdata  (m_rdata),
    .m_rresp  (m_rresp),
    .m_rlast  (m_rlast),
    .m_rvalid (m_rvalid),
    .m_rready (m_rready)
  );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
  parameter real period_ns = 4.0
) (
  output logic aclk
);

  initial aclk = 1'b0;

  always #(period_ns / 2.0) aclk = ~aclk;

endmodule

// File: test/tb_axi3_slave.sv
`timescale 1ns/100ps

module tb_axi3_slave #(
  parameter int          id_width   = 4,
  parameter int          addr_width = 32,
  parameter int          data_width = 32,
  parameter int unsigned data_key   = 32'h5a5a_c3c3
) (
  input  logic                                    aclk,
  input  logic                                    rst,
  input  logic [id_width-1:0]                     m_arid,
  input  logic [addr_width-1:0]                   m_araddr,
  input  logic [axi_conv_pkg::axi3_len_width-1:0] m_arlen,
  input  logic [2:0]                              m_arsize,
  input  logic [1:0]                              m_arburst,
  input  logic                                    m_arvalid,
  output logic                                    m_arready,
  output logic [id_width-1:0]                     m_rid,
  output logic [data_width-1:0]                   m_rdata,
  output logic [1:0]                              m_rresp,
  output logic                                    m_rlast,
  output logic                                    m_rvalid,
  input  logic                                    m_rready
);

  import axi_conv_pkg::*;

  typedef struct packed {
    logic [id_width-1:0]       id;
    logic [addr_width-1:0]     addr;
    logic [axi3_len_width-1:0] len;
    logic [2:0]                size;
    logic [1:0]                burst;
  } piece_t;

  piece_t                pieces [$]; // accepted, not yet answered.
  piece_t                cur;
  logic                  active = 1'b0;
  logic                  r_take;
  logic [addr_width-1:0] a;
  int                    beat = 0;
  int                    seed = 63;

  function automatic logic [addr_width-1:0] beat_addr(piece_t p, int k);
    int                    bytes;
    int                    total;
    logic [addr_width-1:0] lower;
    bytes = 1 << p.size;
    total = bytes * (int'(p.len) + 1);
    lower = p.addr & ~addr_width'(total - 1);
    case (p.burst)
      burst_fixed: return p.addr;
      burst_wrap:  return lower + addr_width'((int'(p.addr - lower) + k * bytes) % total);
      default:     return p.addr + addr_width'(k * bytes);
    endcase
  endfunction

  initial begin
    m_arready = 1'b0;
    m_rid     = '0;
    m_rdata   = '0;
    m_rresp   = '0;
    m_rlast   = 1'b0;
    m_rvalid  = 1'b0;
  end

  always @(posedge aclk) begin
    if (rst) begin
      m_arready <= 1'b0;
      m_rvalid  <= 1'b0;
      active    = 1'b0;
      pieces.delete();
    end else begin
      if (m_arvalid && m_arready) begin
        pieces.push_back(piece_t'({m_arid, m_araddr, m_arlen, m_arsize, m_arburst}));
      end
      m_arready <= ($random(seed) & 3) != 0;
      r_take = m_rvalid && m_rready;
      if (r_take && m_rlast) begin
        active = 1'b0;
      end else if (r_take) begin
        beat = beat + 1;
      end
      if (!active && pieces.size() != 0) begin
        cur    = pieces.pop_front();
        active = 1'b1;
        beat   = 0;
      end
      // a beat on offer stays put until taken.
      if (active && (!m_rvalid || r_take) && ($random(seed) & 3) != 0) begin
        a = beat_addr(cur, beat);
        m_rvalid <= 1'b1;
        m_rid    <= cur.id;
        m_rdata  <= data_width'(a) ^ data_width'(data_key);
        m_rresp  <= a[12] ? resp_slverr : resp_okay;
        m_rlast  <= (beat == int'(cur.len));
      end else if (r_take) begin
        m_rvalid <= 1'b0; // gap.
      end
    end
  end

endmodule

// File: test/tb_checker.sv
`timescale 1ns/100ps

module tb_checker #(
  parameter int          id_width   = 4,
  parameter int          addr_width = 32,
  parameter int          data_width = 32,
  parameter int unsigned data_key   = 32'h5a5a_c3c3
) (
  input  logic                                    aclk,
  input  logic                                    rst,
  input  logic [id_width-1:0]                     s_arid,
  input  logic [addr_width-1:0]                   s_araddr,
  input  logic [axi_conv_pkg::axi4_len_width-1:0] s_arlen,
  input  logic [2:0]                              s_arsize,
  input  logic [1:0]                              s_arburst,
  input  logic                                    s_arvalid,
  input  logic                                    s_arready,
  input  logic [id_width-1:0]                     s_rid,
  input  logic [data_width-1:0]                   s_rdata,
  input  logic [1:0]                              s_rresp,
  input  logic                                    s_rlast,
  input  logic                                    s_rvalid,
  input  logic                                    s_rready,
  input  logic [id_width-1:0]                     m_arid,
  input  logic [addr_width-1:0]                   m_araddr,
  input  logic [axi_conv_pkg::axi3_len_width-1:0] m_arlen,
  input  logic [2:0]                              m_arsize,
  input  logic [1:0]                              m_arburst,
  input  logic                                    m_arvalid,
  input  logic                                    m_arready,
  input  logic                                    m_rready,
  output int                                      errors,
  output int                                      checks,
  output int                                      reqs_seen,
  output int                                      pending
);

  import axi_conv_pkg::*;

  typedef struct packed {
    logic [id_width-1:0]       id;
    logic [addr_width-1:0]     addr;
    logic [axi3_len_width-1:0] len;
    logic [2:0]                size;
    logic [1:0]                burst;
  } piece_t;

  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } beat_t;

  piece_t exp_pieces [$];
  beat_t  exp_beats [$];
  piece_t p;
  beat_t  b;
  logic   reset_seen = 1'b0;

  initial begin
    errors    = 0;
    checks    = 0;
    reqs_seen = 0;
    pending   = 0;
  end

  task automatic compare_value(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
    checks++;
    if (exp_val !== act_val) begin
      errors++;
      $display("ERROR %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp_val, act_val);
    end
  endtask

  // one AXI4 read request into its AXI3 pieces and its R beats.
  function automatic void expand_request(logic [id_width-1:0] id, logic [addr_width-1:0] addr,
                                         logic [axi4_len_width-1:0] len, logic [2:0] size,
                                         logic [1:0] burst);
    int                    bytes;
    int                    total;
    int                    left;
    int                    k;
    logic [addr_width-1:0] lower;
    logic [addr_width-1:0] a;
    piece_t                np;
    beat_t                 nb;
    bytes    = 1 << size;
    np.id    = id;
    np.addr  = addr;
    np.size  = size;
    np.burst = burst;
    if (burst == burst_incr) begin
      left = int'(len) + 1;
      while (left > 0) begin
        np.len = (left > 16) ? 4'd15 : 4'(left - 1);
        exp_pieces.push_back(np);
        np.addr = np.addr + addr_width'(16 * bytes);
        left    = left - 16;
      end
    end else begin
      np.len = len[3:0]; // never more than 16 beats.
      exp_pieces.push_back(np);
    end
    total = bytes * (int'(len) + 1);
    lower = addr & ~addr_width'(total - 1);
    for (k = 0; k <= int'(len); k++) begin
      if (burst == burst_fixed) begin
        a = addr;
      end else if (burst == burst_wrap) begin
        a = lower + addr_width'((int'(addr - lower) + k * bytes) % total);
      end else begin
        a = addr + addr_width'(k * bytes);
      end
      nb.id   = id;
      nb.data = data_width'(a) ^ data_width'(data_key);
      nb.resp = a[12] ? resp_slverr : resp_okay;
      nb.last = (k == int'(len)); // only the request's final beat.
      exp_beats.push_back(nb);
    end
  endfunction

  always @(posedge aclk) begin
    if (rst) begin
      if (reset_seen) begin
        compare_value("s_arready", 64'(0), 64'(s_arready));
        compare_value("m_arvalid", 64'(0), 64'(m_arvalid));
        compare_value("s_rvalid", 64'(0), 64'(s_rvalid));
        compare_value("m_rready", 64'(0), 64'(m_rready));
      end
      reset_seen = 1'b1;
    end else begin
      if (s_arvalid && s_arready) begin
        expand_request(s_arid, s_araddr, s_arlen, s_arsize, s_arburst);
        reqs_seen <= reqs_seen + 1;
      end
      if (m_arvalid && m_arready) begin
        if (exp_pieces.size() == 0) begin
          errors++;
          $display("at %0t ns an AXI3 request went out that no AXI4 request asked for", $time);
        end else begin
          p = exp_pieces.pop_front();
          compare_value("m_arid", 64'(p.id), 64'(m_arid));
          compare_value("m_araddr", 64'(p.addr), 64'(m_araddr));
          compare_value("m_arlen", 64'(p.len), 64'(m_arlen));
          compare_value("m_arsize", 64'(p.size), 64'(m_arsize));
          compare_value("m_arburst", 64'(p.burst), 64'(m_arburst));
        end
      end
      if (s_rvalid && s_rready) begin
        if (exp_beats.size() == 0) begin
          errors++;
          $display("at %0t ns a read beat arrived that no AXI4 request asked for", $time);
        end else begin
          b = exp_beats.pop_front();
          compare_value("s_rid", 64'(b.id), 64'(s_rid));
          compare_value("s_rdata", 64'(b.data), 64'(s_rdata));
          compare_value("s_rresp", 64'(b.resp), 64'(s_rresp));
          compare_value("s_rlast", 64'(b.last), 64'(s_rlast));
        end
      end
      pending <= exp_pieces.size() + exp_beats.size();
    end
  end

endmodule

// File: test/tb_top.sv
`timescale 1ns/100ps

module tb_top;

  import axi_conv_pkg::*;

  localparam int          id_width       = 4;
  localparam int          addr_width     = 32;
  localparam int          data_width     = 32;
  localparam int          queue_depth    = 4;
  localparam int          num_reqs       = 40;
  localparam int          timeout_cycles = num_reqs * 256 * 4 + 1000;
  localparam int unsigned data_key       = 32'h5a5a_c3c3;

  logic                      aclk;
  logic                      rst;
  logic [id_width-1:0]       s_arid;
  logic [addr_width-1:0]     s_araddr;
  logic [axi4_len_width-1:0] s_arlen;
  logic [2:0]                s_arsize;
  logic [1:0]                s_arburst;
  logic                      s_arvalid;
  logic                      s_arready;
  logic [id_width-1:0]       s_rid;
  logic [data_width-1:0]     s_rdata;
  logic [1:0]                s_rresp;
  logic                      s_rlast;
  logic                      s_rvalid;
  logic                      s_rready;
  logic [id_width-1:0]       m_arid;
  logic [addr_width-1:0]     m_araddr;
  logic [axi3_len_width-1:0] m_arlen;
  logic [2:0]                m_arsize;
  logic [1:0]                m_arburst;
  logic                      m_arvalid;
  logic                      m_arready;
  logic [id_width-1:0]       m_rid;
  logic [data_width-1:0]     m_rdata;
  logic [1:0]                m_rresp;
  logic                      m_rlast;
  logic                      m_rvalid;
  logic                      m_rready;

  int                        errors;
  int                        checks;
  int                        reqs_seen;
  int                        pending;
  int                        seed     = 63;
  int                        rdy_seed = 63;
  int                        cycles   = 0;
  int                        i;
  int                        r;
  logic [axi4_len_width-1:0] len;
  logic [1:0]                burst;

  tb_clock #(.period_ns(4.0)) u_clock (.aclk(aclk));

  axi4_to_axi3_read #(
    .id_width   (id_width),
    .addr_width (addr_width),
    .data_width (data_width),
    .queue_depth(queue_depth)
  ) dut (.*);

  tb_axi3_slave #(
    .id_width  (id_width),
    .addr_width(addr_width),
    .data_width(data_width),
    .data_key  (data_key)
  ) u_slave (.*);

  tb_checker #(
    .id_width  (id_width),
    .addr_width(addr_width),
    .data_width(data_width),
    .data_key  (data_key)
  ) u_checker (.*);

  // corner lengths first, random ones after.
  function automatic logic [axi4_len_width-1:0] pick_incr_len(int n, logic [7:0] rnd);
    case (n)
      0:       return 8'd0;
      1:       return 8'd15;
      2:       return 8'd16;
      3:       return 8'd17;
      4:       return 8'd255;
      5:       return 8'd31;
      default: return rnd;
    endcase
  endfunction

  initial begin
    rst       = 1'b1;
    s_arid    = '0;
    s_araddr  = '0;
    s_arlen   = '0;
    s_arsize  = '0;
    s_arburst = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b1;
    repeat (4) @(posedge aclk);
    rst <= 1'b0;
    for (i = 0; i < num_reqs; i++) begin
      r = $random(seed);
      if (i % 10 == 7) begin
        burst = burst_wrap;
        len   = 8'((2 << r[1:0]) - 1); // 2, 4, 8 or 16 beats.
      end else if (i % 10 == 9) begin
        burst = burst_fixed;
        len   = 8'(r[3:0]);
      end else begin
        burst = burst_incr;
        len   = pick_incr_len(i, r[7:0]);
      end
      s_arid    <= id_width'(r >> 8);
      s_araddr  <= addr_width'($random(seed)) & addr_width'(32'h0000_fffc);
      s_arlen   <= len;
      s_arsize  <= 3'd2;
      s_arburst <= burst;
      s_arvalid <= 1'b1;
      @(posedge aclk);
      while (!s_arready) begin
        @(posedge aclk);
      end
      if (r[12]) begin
        s_arvalid <= 1'b0; // idle cycle now and then.
        @(posedge aclk);
      end
    end
    s_arvalid <= 1'b0;
    while (reqs_seen != num_reqs || pending != 0) begin
      @(posedge aclk);
    end
    @(posedge aclk);
    $display("requests: %0d, checks: %0d, errors: %0d", reqs_seen, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  always @(posedge aclk) begin
    if (!rst) begin
      s_rready <= ($random(rdy_seed) & 3) != 0;
    end
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("timeout after %0d cycles, %0d requests seen, %0d expected items left",
               cycles, reqs_seen, pending);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

endmodule

// File: flist.f
design/axi_conv_pkg.sv
design/ar_burst_splitter.sv
design/split_cmd_queue.sv
design/r_axi3_conv.sv
design/axi4_to_axi3_read.sv
test/tb_clock.sv
test/tb_axi3_slave.sv
test/tb_checker.sv
test/tb_top.sv

// File: Makefile
VERILATOR  = verilator
TOP        = tb_top
FLIST      = flist.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
OBJ_DIR    = obj_dir
PASS_MSG   = Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
